//--- dv/cordicModel.svh
/*
 * Bit-exact reference functions for the vectoring CORDIC and the
 * mode-dependent phase error.
 */
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

// Reduce to one circle of 4096 counts.
function automatic int wrapPhase(input int value);
    return value & 'hFFF;
endfunction

// Vectoring CORDIC on the already truncated sample components.
function automatic void computeCordic(
    input  int xIn,
    input  int yIn,
    input  int iterations,
    output int magOut,
    output int phaseOut
);
    int x;
    int y;
    int z;
    int xOld;
    x = xIn;
    y = yIn;
    z = 0;
    // Left half-plane folds over with a half-circle offset.
    if (x < 0) begin
        x = -x;
        y = -y;
        z = 'h800;
    end
    for (int k = 0; k < iterations; k++) begin
        xOld = x;
        if (y >= 0) begin
            x = x + (y >>> k);
            y = y - (xOld >>> k);
            z = wrapPhase(z + int'(atanTable[k]));
        end else begin
            x = x - (y >>> k);
            y = y + (xOld >>> k);
            z = wrapPhase(z - int'(atanTable[k]));
        end
    end
    magOut   = (x >>> 2) & 'h1FFF;
    phaseOut = z;
endfunction

function automatic int modePhaseError(input logic [3:0] modeCode, input int phase);
    case (modeCode)
        PM, FM, FSK2:               return phase;
        BPSK, UQPSK, AUQPSK:        return wrapPhase(phase * 2);
        QPSK, OQPSK, SOQPSK, AQPSK: return wrapPhase((phase - 'h200) * 4);
        default:                    return 0;
    endcase
endfunction

`endif

//--- dv/multiDemodTb.sv
/*
 * Testbench for multiDemod. Random multi-channel stimulus from a fixed
 * seed, a per-channel reference model and latency checks.
 */
`timescale 1ns/1ns
`default_nettype none

module multiDemodTb
    import demodPkg::*;
();

    localparam int NUM_CHANNELS = 4;
    localparam int CORDIC_ITER  = 12;
    localparam int LATENCY      = CORDIC_ITER + 4;
    localparam int DRAIN_LIMIT  = 200;

    logic          clk = 1'b0;
    logic          rst;
    logic          sampleEn;
    iqSample_t     sample;
    logic [CHAN_W-1:0] sampleChannel;
    logic          cfgWrite;
    logic [CHAN_W-1:0] cfgChannel;
    demodMode_t    cfgMode;
    logic          resultEn;
    taggedResult_t result;

    int            seed = 89511;
    int            cycle = 0;
    int            resultErrors = 0;
    int            latencyErrors = 0;
    int            otherErrors = 0;
    bit            drainStalled = 1'b0;

    // Reference model state, one entry per channel.
    int            prevPhase [NUM_CHANNELS];
    int            prevPhaseError [NUM_CHANNELS];
    bit            polarity [NUM_CHANNELS];
    logic [3:0]    modelMode [NUM_CHANNELS];
    taggedResult_t expQ [$];
    int            stampQ [$];

    `include "cordicModel.svh"

    multiDemod #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CORDIC_ITER (CORDIC_ITER)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .sampleEn     (sampleEn),
        .sample       (sample),
        .sampleChannel(sampleChannel),
        .cfgWrite     (cfgWrite),
        .cfgChannel   (cfgChannel),
        .cfgMode      (cfgMode),
        .resultEn     (resultEn),
        .result       (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkResult(input taggedResult_t got, input taggedResult_t expected);
        if (got !== expected) begin
            resultErrors++;
            $display("Fail at %0t: result got %h expected %h", $time, got, expected);
        end
    endtask

    task automatic checkLatency(input int got, input int expected);
        if (got != expected) begin
            latencyErrors++;
            $display("Fail at %0t: latency got %0d expected %0d", $time, got, expected);
        end
    endtask

    // Expected output for one accepted sample, stamped with its arrival cycle.
    task automatic predictResult(input int ch, input iqSample_t s);
        taggedResult_t expected;
        int xIn;
        int yIn;
        int magVal;
        int phaseVal;
        int errVal;
        int freqVal;
        xIn = s.i;
        yIn = s.q;
        xIn = xIn >>> (SAMPLE_W - CORDIC_W);
        yIn = yIn >>> (SAMPLE_W - CORDIC_W);
        computeCordic(xIn, yIn, CORDIC_ITER, magVal, phaseVal);
        errVal  = modePhaseError(modelMode[ch], phaseVal);
        freqVal = wrapPhase(phaseVal - prevPhase[ch]);
        if (freqVal == 'h800) begin
            freqVal = polarity[ch] ? 'h801 : 'h7FF;
            polarity[ch] = ~polarity[ch];
        end
        expected.channel         = CHAN_W'(ch);
        expected.data.mag        = MAG_W'(magVal);
        expected.data.phase      = PHASE_W'(phaseVal);
        expected.data.phaseError = PHASE_W'(errVal);
        expected.data.freq       = PHASE_W'(freqVal);
        expected.data.freqError  = PHASE_W'(wrapPhase(errVal - prevPhaseError[ch]));
        prevPhase[ch]      = phaseVal;
        prevPhaseError[ch] = errVal;
        expQ.push_back(expected);
        stampQ.push_back(cycle + LATENCY);
    endtask

    // Outputs and inputs are sampled mid-cycle.
    always @(negedge clk) begin
        taggedResult_t expected;
        if (!rst) begin
            while (stampQ.size() > 0 && stampQ[0] < cycle) begin
                otherErrors++;
                $display("No result arrived for the sample due at cycle %0d", stampQ[0]);
                void'(stampQ.pop_front());
                void'(expQ.pop_front());
            end
            if (resultEn) begin
                if (expQ.size() == 0) begin
                    otherErrors++;
                    $display("resultEn went high at %0t with no sample outstanding", $time);
                end else begin
                    expected = expQ.pop_front();
                    checkLatency(LATENCY - (stampQ.pop_front() - cycle), LATENCY);
                    checkResult(result, expected);
                end
            end
            if (cfgWrite) begin
                modelMode[cfgChannel] = cfgMode;
            end
            if (sampleEn) begin
                predictResult(int'(sampleChannel), sample);
            end
        end
    end

    task automatic driveSample(input int ch, input int iVal, input int qVal);
        iqSample_t s;
        s.i = SAMPLE_W'(iVal);
        s.q = SAMPLE_W'(qVal);
        @(posedge clk);
        sampleEn      <= 1'b1;
        sample        <= s;
        sampleChannel <= CHAN_W'(ch);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        sampleEn <= 1'b0;
    endtask

    task automatic writeMode(input int ch, input logic [3:0] code);
        @(posedge clk);
        cfgWrite   <= 1'b1;
        cfgChannel <= CHAN_W'(ch);
        cfgMode    <= demodMode_t'(code);
        @(posedge clk);
        cfgWrite   <= 1'b0;
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            otherErrors++;
            drainStalled = 1'b1;
            $display("Timeout with %0d results still outstanding", expQ.size());
        end
    endtask

    initial begin
        rst           <= 1'b1;
        sampleEn      <= 1'b0;
        sample        <= '0;
        sampleChannel <= '0;
        cfgWrite      <= 1'b0;
        cfgChannel    <= '0;
        cfgMode       <= AM;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            prevPhase[c]      = 0;
            prevPhaseError[c] = 0;
            polarity[c]       = 1'b1;
            modelMode[c]      = AM;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // Output must stay quiet with nothing in flight.
        repeat (20) idleCycle();

        // Positive and negative I axis on channel 0, back to back then spaced.
        for (int n = 0; n < 8; n++) begin
            driveSample(0, (n % 2 == 0) ? 80000 : -80000, 0);
        end
        for (int n = 0; n < 4; n++) begin
            idleCycle();
            driveSample(0, (n % 2 == 0) ? 80000 : -80000, 0);
        end
        idleCycle();
        waitForDrain();

        // Each channel steps through all twelve codes over the bursts.
        for (int burst = 0; burst < 12 && !drainStalled; burst++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                writeMode(c, 4'((burst + c * 3) % 12));
            end
            for (int n = 0; n < 40; n++) begin
                if (($random(seed) & 3) == 0) begin
                    idleCycle();
                end else begin
                    driveSample($random(seed) & 3, $random(seed), $random(seed));
                end
            end
            idleCycle();
            waitForDrain();
        end

        $display("Errors: result %0d, latency %0d, other %0d",
                 resultErrors, latencyErrors, otherErrors);
        if (resultErrors + latencyErrors + otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds and runs the multiDemod testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module multiDemodTb -o multiDemodSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/multiDemodSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- source/channelDispatcher.sv
/*
 * Input dispatcher. Registers the shared sample, decodes the channel
 * tag into per-channel strobes and holds each channel's mode.
 */
`timescale 1ns/1ns
`default_nettype none

module channelDispatcher
    import demodPkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    sampleEn,
    input  wire iqSample_t         sample,
    input  wire [CHAN_W-1:0]       sampleChannel,
    input  wire                    cfgWrite,
    input  wire [CHAN_W-1:0]       cfgChannel,
    input  wire demodMode_t        cfgMode,
    output logic [NUM_CHANNELS-1:0] chanEn,
    output iqSample_t              chanSample,
    output demodMode_t             chanMode [NUM_CHANNELS]
);

    // One-hot strobe, one cycle after the input.
    always_ff @(posedge clk) begin
        if (rst) begin
            chanEn <= '0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                chanEn[c] <= sampleEn && (sampleChannel == CHAN_W'(c));
            end
        end
    end

    // All channels see the same sample word.
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            chanSample <= sample;
        end
    end

    // Mode registers.
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (rst) begin
                chanMode[c] <= AM;
            end else if (cfgWrite && (cfgChannel == CHAN_W'(c))) begin
                chanMode[c] <= cfgMode;
            end
        end
    end

    // A sample tagged for a missing channel would be silently lost.
    channelInRange: assert property (
        @(posedge clk) disable iff (rst)
        sampleEn |-> (int'(sampleChannel) < NUM_CHANNELS)
    );

endmodule

`default_nettype wire

//--- source/cordicVectoring.sv
/*
 * Pipelined vectoring CORDIC. Quadrant fold stage followed by one
 * rotation stage per iteration, giving magnitude and phase.
 */
`timescale 1ns/1ns
`default_nettype none

module cordicVectoring
    import demodPkg::*;
#(
    parameter int CORDIC_ITER = 12
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        en,
    input  wire signed [CORDIC_W-1:0]  x,
    input  wire signed [CORDIC_W-1:0]  y,
    output logic       [MAG_W-1:0]     mag,
    output logic signed [PHASE_W-1:0]  phase,
    output logic                       enOut
);

    // Two guard bits cover the negated minimum and the CORDIC gain.
    localparam int XW = CORDIC_W + 2;

    logic signed [XW-1:0]      xExt;
    logic signed [XW-1:0]      yExt;
    logic signed [XW-1:0]      xPipe [0:CORDIC_ITER];
    logic signed [XW-1:0]      yPipe [0:CORDIC_ITER];
    logic        [PHASE_W-1:0] zPipe [0:CORDIC_ITER];
    logic        [CORDIC_ITER:0] validPipe;

    assign xExt = x;
    assign yExt = y;

    // Valid bit travels alongside each vector.
    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[CORDIC_ITER-1:0], en};
        end
    end

    // Fold into the right half-plane, then the rotation stages.
    // Phase accumulates modulo a full circle.
    always_ff @(posedge clk) begin
        if (xExt < 0) begin
            xPipe[0] <= -xExt;
            yPipe[0] <= -yExt;
            zPipe[0] <= HALF_CIRCLE;
        end else begin
            xPipe[0] <= xExt;
            yPipe[0] <= yExt;
            zPipe[0] <= '0;
        end
        for (int k = 0; k < CORDIC_ITER; k++) begin
            if (yPipe[k] >= 0) begin
                // Vector above the axis, rotate clockwise.
                xPipe[k+1] <= xPipe[k] + (yPipe[k] >>> k);
                yPipe[k+1] <= yPipe[k] - (xPipe[k] >>> k);
                zPipe[k+1] <= zPipe[k] + atanTable[k];
            end else begin
                xPipe[k+1] <= xPipe[k] - (yPipe[k] >>> k);
                yPipe[k+1] <= yPipe[k] + (xPipe[k] >>> k);
                zPipe[k+1] <= zPipe[k] - atanTable[k];
            end
        end
    end

    // Final x is non-negative, so the sign bit is dropped with the LSBs.
    assign mag   = xPipe[CORDIC_ITER][XW-2 -: MAG_W];
    assign phase = zPipe[CORDIC_ITER];
    assign enOut = validPipe[CORDIC_ITER];

    // Fixed latency regardless of how many vectors are in flight.
    enLatency: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst, CORDIC_ITER + 1) |-> (enOut == $past(en, CORDIC_ITER + 1))
    );

endmodule

`default_nettype wire

//--- source/demodChannel.sv
/*
 * One demodulator channel. CORDIC magnitude and phase, mode-dependent
 * phase error, and frequency and frequency error by first difference.
 */
`timescale 1ns/1ns
`default_nettype none

module demodChannel
    import demodPkg::*;
#(
    parameter int CORDIC_ITER = 12
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               en,
    input  wire iqSample_t    sample,
    input  wire demodMode_t   mode,
    output logic              resultEn,
    output demodResult_t      result
);

    logic        [MAG_W-1:0]   cordicMag;
    logic signed [PHASE_W-1:0] cordicPhase;
    logic                      cordicEn;

    logic signed [PHASE_W-1:0] qpskPhase;
    logic signed [PHASE_W-1:0] phaseErrorNext;
    logic signed [PHASE_W-1:0] phaseDiff;
    logic signed [PHASE_W-1:0] phaseErrorDiff;

    logic signed [PHASE_W-1:0] prevPhase;
    logic signed [PHASE_W-1:0] prevPhaseError;
    logic                      polarityFlag;

    // Only the top CORDIC_W bits of each sample reach the CORDIC.
    cordicVectoring #(
        .CORDIC_ITER(CORDIC_ITER)
    ) cordic (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .x    (sample.i[SAMPLE_W-1 -: CORDIC_W]),
        .y    (sample.q[SAMPLE_W-1 -: CORDIC_W]),
        .mag  (cordicMag),
        .phase(cordicPhase),
        .enOut(cordicEn)
    );

    // Constellation offset removed before quadrupling.
    assign qpskPhase = cordicPhase - EIGHTH_CIRCLE;

    always_comb begin
        case (mode)
            PM, FM, FSK2: begin
                phaseErrorNext = cordicPhase;
            end
            BPSK, UQPSK, AUQPSK: begin
                // Doubling strips the BPSK modulation.
                phaseErrorNext = {cordicPhase[PHASE_W-2:0], 1'b0};
            end
            QPSK, OQPSK, SOQPSK, AQPSK: begin
                phaseErrorNext = {qpskPhase[PHASE_W-3:0], 2'b00};
            end
            default: begin
                phaseErrorNext = '0;
            end
        endcase
    end

    assign phaseDiff      = cordicPhase - prevPhase;
    assign phaseErrorDiff = phaseErrorNext - prevPhaseError;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultEn       <= 1'b0;
            result         <= '0;
            prevPhase      <= '0;
            prevPhaseError <= '0;
            polarityFlag   <= 1'b1;
        end else begin
            resultEn <= cordicEn;
            if (cordicEn) begin
                result.mag        <= cordicMag;
                result.phase      <= cordicPhase;
                result.phaseError <= phaseErrorNext;
                result.freqError  <= phaseErrorDiff;
                // A half-circle jump is ambiguous, so alternate its sign.
                if (phaseDiff == HALF_CIRCLE) begin
                    polarityFlag <= ~polarityFlag;
                    if (polarityFlag) begin
                        result.freq <= 12'h801;
                    end else begin
                        result.freq <= 12'h7FF;
                    end
                end else begin
                    result.freq <= phaseDiff;
                end
                prevPhase      <= cordicPhase;
                prevPhaseError <= phaseErrorNext;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/demodPkg.sv
/*
 * Shared widths, phase constants, demodulation modes, sample and result
 * structs, and the CORDIC arctangent table.
 */
`default_nettype none

package demodPkg;

    localparam int SAMPLE_W = 18;
    localparam int CORDIC_W = 14;
    localparam int PHASE_W  = 12;
    localparam int MAG_W    = 13;
    localparam int CHAN_W   = 2;
    localparam int ATAN_LEN = 16;

    // Full circle is 4096 counts.
    localparam logic [PHASE_W-1:0] HALF_CIRCLE   = 12'h800;
    localparam logic [PHASE_W-1:0] EIGHTH_CIRCLE = 12'h200;

    // Codes above AQPSK fall into the default case.
    typedef enum logic [3:0] {
        AM     = 4'd0,
        PM     = 4'd1,
        FM     = 4'd2,
        FSK2   = 4'd3,
        BPSK   = 4'd4,
        UQPSK  = 4'd5,
        AUQPSK = 4'd6,
        QPSK   = 4'd7,
        OQPSK  = 4'd8,
        SOQPSK = 4'd9,
        AQPSK  = 4'd10
    } demodMode_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } iqSample_t;

    typedef struct packed {
        logic        [MAG_W-1:0]   mag;
        logic signed [PHASE_W-1:0] phase;
        logic signed [PHASE_W-1:0] phaseError;
        logic signed [PHASE_W-1:0] freq;
        logic signed [PHASE_W-1:0] freqError;
    } demodResult_t;

    typedef struct packed {
        logic [CHAN_W-1:0] channel;
        demodResult_t      data;
    } taggedResult_t;

    // atan(2^-k) scaled to 4096 counts per circle, rounded.
    localparam logic [PHASE_W-1:0] atanTable [0:ATAN_LEN-1] = '{
        12'd512, 12'd302, 12'd160, 12'd81,
        12'd41,  12'd20,  12'd10,  12'd5,
        12'd3,   12'd1,   12'd1,   12'd0,
        12'd0,   12'd0,   12'd0,   12'd0
    };

endpackage

`default_nettype wire

//--- source/multiDemod.sv
/*
 * Multi-channel demodulator top level. Dispatcher, one demodChannel per
 * channel and the result collector.
 */
`timescale 1ns/1ns
`default_nettype none

module multiDemod
    import demodPkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int CORDIC_ITER  = 12
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               sampleEn,
    input  wire iqSample_t    sample,
    input  wire [CHAN_W-1:0]  sampleChannel,
    input  wire               cfgWrite,
    input  wire [CHAN_W-1:0]  cfgChannel,
    input  wire demodMode_t   cfgMode,
    output logic              resultEn,
    output taggedResult_t     result
);

    logic [NUM_CHANNELS-1:0] chanEn;
    iqSample_t               chanSample;
    demodMode_t              chanMode [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] chanResultEn;
    demodResult_t            chanResult [NUM_CHANNELS];

    channelDispatcher #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) dispatcher (
        .clk          (clk),
        .rst          (rst),
        .sampleEn     (sampleEn),
        .sample       (sample),
        .sampleChannel(sampleChannel),
        .cfgWrite     (cfgWrite),
        .cfgChannel   (cfgChannel),
        .cfgMode      (cfgMode),
        .chanEn       (chanEn),
        .chanSample   (chanSample),
        .chanMode     (chanMode)
    );

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : gChannel
        demodChannel #(
            .CORDIC_ITER(CORDIC_ITER)
        ) channel (
            .clk     (clk),
            .rst     (rst),
            .en      (chanEn[c]),
            .sample  (chanSample),
            .mode    (chanMode[c]),
            .resultEn(chanResultEn[c]),
            .result  (chanResult[c])
        );
    end

    resultCollector #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) collector (
        .clk         (clk),
        .rst         (rst),
        .chanResultEn(chanResultEn),
        .chanResult  (chanResult),
        .resultEn    (resultEn),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- source/resultCollector.sv
/*
 * Result collector. Tags the single active channel result with its
 * index and registers it onto the output stream.
 */
`timescale 1ns/1ns
`default_nettype none

module resultCollector
    import demodPkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [NUM_CHANNELS-1:0] chanResultEn,
    input  wire demodResult_t      chanResult [NUM_CHANNELS],
    output logic                   resultEn,
    output taggedResult_t          result
);

    logic [CHAN_W-1:0] selChannel;

    // Strobe to index encoder.
    always_comb begin
        selChannel = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (chanResultEn[c]) begin
                selChannel = CHAN_W'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultEn <= 1'b0;
        end else begin
            resultEn <= |chanResultEn;
        end
    end

    always_ff @(posedge clk) begin
        if (|chanResultEn) begin
            result.channel <= selChannel;
            result.data    <= chanResult[selChannel];
        end
    end

    // Equal channel latency keeps strobes from colliding.
    singleStrobe: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(chanResultEn)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+dv
source/demodPkg.sv
source/cordicVectoring.sv
source/demodChannel.sv
source/channelDispatcher.sv
source/resultCollector.sv
source/multiDemod.sv
dv/multiDemodTb.sv
